//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Eight entries, so a tag is three bits wide
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);
    localparam int DATA_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int OP_W      = 3;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [OP_W-1:0]      op_t;

    // Shifts take only the low five bits of b
    localparam op_t OP_ADD = 3'd0;
    localparam op_t OP_SUB = 3'd1;
    localparam op_t OP_AND = 3'd2;
    localparam op_t OP_OR  = 3'd3;
    localparam op_t OP_XOR = 3'd4;
    localparam op_t OP_SLL = 3'd5;
    localparam op_t OP_SRL = 3'd6;
    localparam op_t OP_MUL = 3'd7;

    // Instruction as it arrives on the dispatch stream
    typedef struct packed {
        op_t      op;
        reg_idx_t rdst;
        data_t    a;
        data_t    b;
    } dispatch_req_t;

    // Request toward one execution unit, already carrying its reorder-buffer tag
    typedef struct packed {
        logic     valid;
        op_t      op;
        rob_tag_t tag;
        data_t    a;
        data_t    b;
    } issue_req_t;

    // One common-data-bus port
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    data;
    } cdb_t;

    // Head entry presented to the register file
    typedef struct packed {
        reg_idx_t rdst;
        rob_tag_t tag;
        data_t    data;
    } retire_t;

endpackage

`default_nettype wire

//--- decode/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,

    // Dispatch stream
    input  wire logic                   i_disp_valid,
    input  wire rob_pkg::dispatch_req_t i_disp,
    output logic                        o_disp_ready,

    // Tag allocation in the reorder buffer
    input  wire logic                   i_rob_full,
    input  wire rob_pkg::rob_tag_t      i_alloc_tag,
    output logic                        o_alloc_valid,
    output rob_pkg::reg_idx_t           o_alloc_rdst,

    // Issue toward the two execution units
    output rob_pkg::issue_req_t         o_alu_issue,
    output rob_pkg::issue_req_t         o_mul_issue
);

    logic              disp_xfer;
    logic              is_mul;
    logic              alu_valid_q;
    logic              mul_valid_q;
    rob_pkg::op_t      op_q;
    rob_pkg::rob_tag_t tag_q;
    rob_pkg::data_t    a_q;
    rob_pkg::data_t    b_q;

    // Ready only looks at buffer state so it never depends on valid
    assign o_disp_ready  = ~i_rob_full;
    assign disp_xfer     = i_disp_valid & o_disp_ready;
    assign is_mul        = (i_disp.op == rob_pkg::OP_MUL);

    assign o_alloc_valid = disp_xfer;
    assign o_alloc_rdst  = i_disp.rdst;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= disp_xfer & ~is_mul;
            mul_valid_q <= disp_xfer & is_mul;
        end
    end

    // One payload register serves both units since only one valid is ever set
    always_ff @(posedge clk) begin
        if (disp_xfer) begin
            op_q  <= i_disp.op;
            tag_q <= i_alloc_tag;
            a_q   <= i_disp.a;
            b_q   <= i_disp.b;
        end
    end

    always_comb begin
        o_alu_issue.valid = alu_valid_q;
        o_alu_issue.op    = op_q;
        o_alu_issue.tag   = tag_q;
        o_alu_issue.a     = a_q;
        o_alu_issue.b     = b_q;

        o_mul_issue.valid = mul_valid_q;
        o_mul_issue.op    = op_q;
        o_mul_issue.tag   = tag_q;
        o_mul_issue.a     = a_q;
        o_mul_issue.b     = b_q;
    end

endmodule

`default_nettype wire

//--- execute/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic                clk,
    input  wire logic                i_arst_n,

    input  wire rob_pkg::issue_req_t i_issue,

    // Common data bus port 0
    output rob_pkg::cdb_t            o_cdb
);

    logic [4:0]        shamt;
    rob_pkg::data_t    result;
    logic              valid_q;
    rob_pkg::rob_tag_t tag_q;
    rob_pkg::data_t    data_q;

    assign shamt = i_issue.b[4:0];

    always_comb begin
        case (i_issue.op)
            rob_pkg::OP_ADD: result = i_issue.a + i_issue.b;
            rob_pkg::OP_SUB: result = i_issue.a - i_issue.b;
            rob_pkg::OP_AND: result = i_issue.a & i_issue.b;
            rob_pkg::OP_OR:  result = i_issue.a | i_issue.b;
            rob_pkg::OP_XOR: result = i_issue.a ^ i_issue.b;
            rob_pkg::OP_SLL: result = i_issue.a << shamt;
            rob_pkg::OP_SRL: result = i_issue.a >> shamt;
            // Multiplies never reach this unit
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue.valid) begin
            tag_q  <= i_issue.tag;
            data_q <= result;
        end
    end

    assign o_cdb.valid = valid_q;
    assign o_cdb.tag   = tag_q;
    assign o_cdb.data  = data_q;

endmodule

`default_nettype wire

//--- execute/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int P_MUL_STAGES = 3
) (
    input  wire logic                clk,
    input  wire logic                i_arst_n,

    input  wire rob_pkg::issue_req_t i_issue,

    // Common data bus port 1
    output rob_pkg::cdb_t            o_cdb
);

    rob_pkg::data_t    pp_d [4];
    rob_pkg::data_t    pp_q [4];
    logic              valid_q [1:P_MUL_STAGES];
    rob_pkg::rob_tag_t tag_q [1:P_MUL_STAGES];
    rob_pkg::data_t    data_q [2:P_MUL_STAGES];

    // Each byte of b times a is moved to its weight and cut to the low 32 bits
    always_comb begin
        logic [39:0] part;
        for (int k = 0; k < 4; k++) begin
            part    = 40'(i_issue.a) * 40'(i_issue.b[8*k +: 8]);
            pp_d[k] = rob_pkg::data_t'(part << (8 * k));
        end
    end

    // Valid travels alongside every stage
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 1; s <= P_MUL_STAGES; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else begin
            valid_q[1] <= i_issue.valid;
            for (int s = 2; s <= P_MUL_STAGES; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        // Stage 1 holds the partial products
        for (int k = 0; k < 4; k++) begin
            pp_q[k] <= pp_d[k];
        end
        tag_q[1] <= i_issue.tag;

        // Stage 2 adds them up
        data_q[2] <= pp_q[0] + pp_q[1] + pp_q[2] + pp_q[3];
        tag_q[2]  <= tag_q[1];

        // Any further stages just carry the product along
        for (int s = 3; s <= P_MUL_STAGES; s++) begin
            data_q[s] <= data_q[s-1];
            tag_q[s]  <= tag_q[s-1];
        end
    end

    assign o_cdb.valid = valid_q[P_MUL_STAGES];
    assign o_cdb.tag   = tag_q[P_MUL_STAGES];
    assign o_cdb.data  = data_q[P_MUL_STAGES];

endmodule

`default_nettype wire

//--- result/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic              clk,
    input  wire logic              i_arst_n,

    // Allocation at the tail
    input  wire logic              i_alloc_valid,
    input  wire rob_pkg::reg_idx_t i_alloc_rdst,
    output rob_pkg::rob_tag_t      o_alloc_tag,
    output logic                   o_full,

    // Completion from both bus ports
    input  wire rob_pkg::cdb_t     i_cdb_alu,
    input  wire rob_pkg::cdb_t     i_cdb_mul,

    // In-order retire toward the register file
    output logic                   o_ret_valid,
    output rob_pkg::retire_t       o_ret,
    input  wire logic              i_ret_ready
);

    localparam int CNT_W = $clog2(rob_pkg::ROB_DEPTH + 1);

    logic [rob_pkg::ROB_DEPTH-1:0] ent_valid;
    logic [rob_pkg::ROB_DEPTH-1:0] ent_done;
    rob_pkg::reg_idx_t             ent_rdst [rob_pkg::ROB_DEPTH];
    rob_pkg::data_t                ent_data [rob_pkg::ROB_DEPTH];

    rob_pkg::rob_tag_t head_q;
    rob_pkg::rob_tag_t tail_q;
    logic [CNT_W-1:0]  count_q;
    logic              alloc;
    logic              retire;

    assign o_full      = (count_q == CNT_W'(rob_pkg::ROB_DEPTH));
    assign o_alloc_tag = tail_q;

    // No entry is allocated while the buffer is full
    assign alloc  = i_alloc_valid & ~o_full;
    assign retire = o_ret_valid & i_ret_ready;

    // Retire shows the head entry straight from its state
    assign o_ret_valid = ent_valid[head_q] & ent_done[head_q];
    assign o_ret.rdst  = ent_rdst[head_q];
    assign o_ret.tag   = head_q;
    assign o_ret.data  = ent_data[head_q];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head and tail only coincide when empty or full, so alloc and retire never
    // touch the same entry on one edge
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                if (retire && head_q == rob_pkg::rob_tag_t'(i)) begin
                    ent_valid[i] <= 1'b0;
                    ent_done[i]  <= 1'b0;
                end else if (alloc && tail_q == rob_pkg::rob_tag_t'(i)) begin
                    ent_valid[i] <= 1'b1;
                    ent_done[i]  <= 1'b0;
                end else if ((i_cdb_alu.valid && i_cdb_alu.tag == rob_pkg::rob_tag_t'(i)) ||
                             (i_cdb_mul.valid && i_cdb_mul.tag == rob_pkg::rob_tag_t'(i))) begin
                    ent_done[i] <= 1'b1;
                end
            end
        end
    end

    // The two ports always carry different tags when both are valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            if (alloc && tail_q == rob_pkg::rob_tag_t'(i)) begin
                ent_rdst[i] <= i_alloc_rdst;
            end
            if (i_cdb_alu.valid && i_cdb_alu.tag == rob_pkg::rob_tag_t'(i)) begin
                ent_data[i] <= i_cdb_alu.data;
            end else if (i_cdb_mul.valid && i_cdb_mul.tag == rob_pkg::rob_tag_t'(i)) begin
                ent_data[i] <= i_cdb_mul.data;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
    parameter int P_MUL_STAGES = 3
) (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,

    // Dispatch stream in program order
    input  wire logic                   i_disp_valid,
    input  wire rob_pkg::dispatch_req_t i_disp,
    output logic                        o_disp_ready,

    // Retire stream toward the register file
    output logic                        o_ret_valid,
    output rob_pkg::retire_t            o_ret,
    input  wire logic                   i_ret_ready
);

    logic                rob_full;
    rob_pkg::rob_tag_t   alloc_tag;
    logic                alloc_valid;
    rob_pkg::reg_idx_t   alloc_rdst;
    rob_pkg::issue_req_t alu_issue;
    rob_pkg::issue_req_t mul_issue;
    rob_pkg::cdb_t       cdb_alu;
    rob_pkg::cdb_t       cdb_mul;

    op_decode u_op_decode (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_disp_valid  (i_disp_valid),
        .i_disp        (i_disp),
        .o_disp_ready  (o_disp_ready),
        .i_rob_full    (rob_full),
        .i_alloc_tag   (alloc_tag),
        .o_alloc_valid (alloc_valid),
        .o_alloc_rdst  (alloc_rdst),
        .o_alu_issue   (alu_issue),
        .o_mul_issue   (mul_issue)
    );

    alu_unit u_alu_unit (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_issue  (alu_issue),
        .o_cdb    (cdb_alu)
    );

    mul_unit #(
        .P_MUL_STAGES (P_MUL_STAGES)
    ) u_mul_unit (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_issue  (mul_issue),
        .o_cdb    (cdb_mul)
    );

    reorder_buffer u_reorder_buffer (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_alloc_valid (alloc_valid),
        .i_alloc_rdst  (alloc_rdst),
        .o_alloc_tag   (alloc_tag),
        .o_full        (rob_full),
        .i_cdb_alu     (cdb_alu),
        .i_cdb_mul     (cdb_mul),
        .o_ret_valid   (o_ret_valid),
        .o_ret         (o_ret),
        .i_ret_ready   (i_ret_ready)
    );

endmodule

`default_nettype wire

//--- tb/result_checker.sv
`timescale 1ns/1ps
`default_nettype none

module result_checker (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,
    input  wire logic [7:0]             i_test_num,
    input  wire logic                   i_disp_valid,
    input  wire rob_pkg::dispatch_req_t i_disp,
    input  wire logic                   i_disp_ready,
    input  wire logic                   i_ret_valid,
    input  wire rob_pkg::retire_t       i_ret,
    input  wire logic                   i_ret_ready,
    input  wire logic                   i_end,
    output int                          o_errors,
    output int                          o_checked,
    output int                          o_pending,
    output int                          o_tests
);

    rob_pkg::retire_t  exp_q [$];
    logic [7:0]        test_q [$];
    rob_pkg::rob_tag_t next_tag = '0;
    int                outstanding = 0;
    int                errors = 0;
    int                checked = 0;
    int                tests = 0;
    int                test_results = 0;
    int                test_errors = 0;
    logic [7:0]        cur_test = '0;
    logic              closed = 1'b0;

    assign o_errors  = errors;
    assign o_checked = checked;
    assign o_pending = outstanding;
    assign o_tests   = tests;

    // Multiply keeps only the low 32 bits of the full product
    function automatic rob_pkg::data_t expected_value(rob_pkg::op_t op, rob_pkg::data_t a,
                                                      rob_pkg::data_t b);
        logic [63:0] prod;
        prod = 64'(a) * 64'(b);
        case (op)
            rob_pkg::OP_ADD: return a + b;
            rob_pkg::OP_SUB: return a - b;
            rob_pkg::OP_AND: return a & b;
            rob_pkg::OP_OR:  return a | b;
            rob_pkg::OP_XOR: return a ^ b;
            rob_pkg::OP_SLL: return a << b[4:0];
            rob_pkg::OP_SRL: return a >> b[4:0];
            default:         return prod[31:0];
        endcase
    endfunction

    task automatic value_error(string what, logic [31:0] got, logic [31:0] want);
        $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, want);
        errors++;
        test_errors++;
    endtask

    task automatic report_test();
        $display("test %0d finished: %0d results, %0d errors", cur_test, test_results,
                 test_errors);
        tests++;
    endtask

    // Inputs are sampled on the rising edge before the DUT state moves on
    always @(posedge clk) begin
        rob_pkg::retire_t exp;
        logic [7:0]       tnum;
        if (i_arst_n) begin
            // Ready must fall exactly when eight entries are outstanding
            if (i_disp_ready !== (outstanding < rob_pkg::ROB_DEPTH)) begin
                value_error("o_disp_ready", 32'(i_disp_ready),
                            32'(outstanding < rob_pkg::ROB_DEPTH));
            end
            // An empty buffer has nothing to retire
            if (outstanding == 0 && i_ret_valid !== 1'b0) begin
                value_error("o_ret_valid", 32'(i_ret_valid), 32'd0);
            end
            if (i_ret_valid && i_ret_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Retire at time %0t arrived with no outstanding dispatch", $time);
                    errors++;
                end else begin
                    exp  = exp_q.pop_front();
                    tnum = test_q.pop_front();
                    if (tnum != cur_test) begin
                        if (test_results > 0) begin
                            report_test();
                        end
                        cur_test     = tnum;
                        test_results = 0;
                        test_errors  = 0;
                    end
                    if (i_ret.tag !== exp.tag) begin
                        value_error("retire tag", 32'(i_ret.tag), 32'(exp.tag));
                    end
                    if (i_ret.rdst !== exp.rdst) begin
                        value_error("retire rdst", 32'(i_ret.rdst), 32'(exp.rdst));
                    end
                    if (i_ret.data !== exp.data) begin
                        value_error("retire data", i_ret.data, exp.data);
                    end
                    test_results++;
                    checked++;
                    outstanding--;
                end
            end
            if (i_disp_valid && i_disp_ready) begin
                exp.rdst = i_disp.rdst;
                exp.tag  = next_tag;
                exp.data = expected_value(i_disp.op, i_disp.a, i_disp.b);
                exp_q.push_back(exp);
                test_q.push_back(i_test_num);
                next_tag = next_tag + 1'b1;
                outstanding++;
            end
            if (i_end && !closed) begin
                if (test_results > 0) begin
                    report_test();
                end
                closed = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 7;

    logic                   clk = 1'b0;
    logic                   i_arst_n;
    logic                   i_disp_valid;
    rob_pkg::dispatch_req_t i_disp;
    logic                   o_disp_ready;
    logic                   o_ret_valid;
    rob_pkg::retire_t       o_ret;
    logic                   i_ret_ready;
    logic [7:0]             test_num;
    logic                   run_end;

    logic [31:0] stim [0:MAX_LINES*FIELDS-1];
    integer      seed = 18;
    int          stall_left = 0;
    int          tb_errors = 0;
    int          errors;
    int          checked;
    int          pending;
    int          tests;
    logic        aborted = 1'b0;

    always #2 clk = ~clk;

    ooo_core_top #(.P_MUL_STAGES(3)) UUT (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_disp_valid (i_disp_valid),
        .i_disp       (i_disp),
        .o_disp_ready (o_disp_ready),
        .o_ret_valid  (o_ret_valid),
        .o_ret        (o_ret),
        .i_ret_ready  (i_ret_ready)
    );

    result_checker u_checker (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_test_num   (test_num),
        .i_disp_valid (i_disp_valid),
        .i_disp       (i_disp),
        .i_disp_ready (o_disp_ready),
        .i_ret_valid  (o_ret_valid),
        .i_ret        (o_ret),
        .i_ret_ready  (i_ret_ready),
        .i_end        (run_end),
        .o_errors     (errors),
        .o_checked    (checked),
        .o_pending    (pending),
        .o_tests      (tests)
    );

    // Steps to the next falling edge and drives retire ready there
    task automatic next_cycle();
        @(negedge clk);
        if (stall_left > 0) begin
            i_ret_ready = 1'b0;
            stall_left--;
        end else begin
            i_ret_ready = (($random(seed) & 3) != 0);
        end
    endtask

    task automatic send_line(int idx);
        int   base;
        int   waited;
        logic accepted;
        base     = idx * FIELDS;
        accepted = 1'b0;
        i_disp_valid = 1'b0;
        repeat (stim[base+5]) next_cycle();
        test_num     = stim[base][7:0];
        i_disp.op    = stim[base+1][2:0];
        i_disp.rdst  = stim[base+2][4:0];
        i_disp.a     = stim[base+3];
        i_disp.b     = stim[base+4];
        i_disp_valid = 1'b1;
        if (stim[base+6] != 0) begin
            stall_left = stim[base+6];
        end
        // Ready depends on state only, so its value here decides the next edge
        for (waited = 0; waited < 200 && !accepted; waited++) begin
            accepted = o_disp_ready;
            next_cycle();
        end
        i_disp_valid = 1'b0;
        if (!accepted) begin
            $display("Dispatch of input line %0d was not accepted within 200 cycles", idx);
            tb_errors++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int idx;
        int drain;
        i_arst_n     = 1'b0;
        i_disp_valid = 1'b0;
        i_disp       = '0;
        i_ret_ready  = 1'b0;
        test_num     = '0;
        run_end      = 1'b0;
        for (idx = 0; idx < MAX_LINES * FIELDS; idx++) begin
            stim[idx] = '0;
        end
        $readmemh("tb/ooo_input.txt", stim);

        repeat (5) next_cycle();
        i_arst_n = 1'b1;
        next_cycle();

        // A zero test number ends the list
        for (idx = 0; idx < MAX_LINES && stim[idx*FIELDS] != 0 && !aborted; idx++) begin
            send_line(idx);
        end

        for (drain = 0; drain < 500 && pending != 0; drain++) begin
            next_cycle();
        end
        if (pending != 0) begin
            $display("retire stream stopped with %0d results missing", pending);
            tb_errors++;
        end
        run_end = 1'b1;
        next_cycle();
        next_cycle();

        $display("tests %0d, results checked %0d, errors %0d", tests, checked,
                 errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/ooo_input.txt
// test op rdst a b gap stall, all hex, one instruction per line
// op 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 mul
01 0 01 00000005 00000007 02 00
01 1 02 00000003 0000000a 00 00
01 2 03 f0f0ff00 0ff00ff0 00 00
01 3 04 12340000 00005678 00 00
01 4 05 aaaa5555 ffff0000 00 00
01 5 06 00000001 00000024 00 00
01 6 07 80000000 0000003f 00 00
01 5 08 deadbeef 00000108 01 00
01 6 09 deadbeef 00000010 00 00
02 7 0a ffffffff ffffffff 03 00
02 7 0b 12345678 9abcdef0 00 00
02 7 0c 80000000 00000002 00 00
02 7 0d 0001ffff 0001ffff 00 00
03 7 10 00001234 00005678 04 00
03 0 11 00000001 00000001 00 00
03 1 12 00000010 00000001 00 00
03 4 13 ffffffff 0000ffff 00 00
04 0 01 00000100 00000001 02 1e
04 7 02 00000003 00000005 00 00
04 1 03 00000000 00000001 00 00
04 3 04 00f00000 0000000f 00 00
04 7 05 fffffffe 00000010 00 00
04 2 06 ffff0000 12345678 00 00
04 5 07 00000003 0000001f 00 00
04 6 08 f0000000 00000004 00 00
04 0 09 7fffffff 00000001 00 00
04 4 0a 0000ffff ffffffff 00 00
05 7 11 0badf00d 00c0ffee 00 00
05 0 12 11111111 22222222 01 00
05 6 13 ffffffff 00000021 00 00
05 7 14 00010001 00010001 00 00
05 1 15 00000000 7fffffff 02 00
05 5 16 c0000001 00000001 00 00
05 7 17 deadbeef 00000000 00 00
05 3 18 0f0f0f0f f0f0f0f0 00 00
05 2 19 13579bdf 2468ace0 01 00
05 7 1a ffffffff 00000002 00 00

//--- src.f
common/rob_pkg.sv
decode/op_decode.sv
execute/alu_unit.sv
execute/mul_unit.sv
result/reorder_buffer.sv
logic/ooo_core_top.sv
tb/result_checker.sv
tb/tb_ooo_core.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - common/rob_pkg.sv
  - decode/op_decode.sv
  - execute/alu_unit.sv
  - execute/mul_unit.sv
  - result/reorder_buffer.sv
  - logic/ooo_core_top.sv
  - target: test
    files:
      - tb/result_checker.sv
      - tb/tb_ooo_core.sv
